/* src/lsu_config.svh */
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

`define LSU_XLEN        32              // Data and address width

// Data RAM window, one word per four bytes
`define LSU_RAM_BASE    32'h0000_2000
`define LSU_RAM_LAST    32'h0000_3FFF
`define LSU_RAM_WORDS   2048

`define LSU_LEDR_BASE   32'h0000_7000   // Red LEDs
`define LSU_LEDR_LAST   32'h0000_700F
`define LSU_LEDG_BASE   32'h0000_7010   // Green LEDs
`define LSU_LEDG_LAST   32'h0000_701F
`define LSU_HEX_BASE    32'h0000_7020   // Digits 0-3 then 4-7
`define LSU_HEX_LAST    32'h0000_7027
`define LSU_SW_BASE     32'h0000_7800   // Switches
`define LSU_SW_LAST     32'h0000_780F
`define LSU_BTN_BASE    32'h0000_7810   // Buttons
`define LSU_BTN_LAST    32'h0000_781F

`define LSU_LEDR_W      17
`define LSU_LEDG_W      8
`define LSU_SW_W        18
`define LSU_BTN_W       10

`define LSU_HEX_DIGITS  8
`define LSU_HEX_SEG_W   7               // Segment a..g, no dot

`endif

/* src/lsu_pkg.sv */
`include "lsu_config.svh"

package lsu_pkg;

  // RISC-V funct3 encodings for loads and stores
  typedef enum logic [2:0] {
    LSU_B  = 3'd0,
    LSU_H  = 3'd1,
    LSU_W  = 3'd2,
    LSU_BU = 3'd4,
    LSU_HU = 3'd5
  } lsu_size_e;

  typedef struct packed {
    logic [`LSU_XLEN-1:0] addr;   // Byte address
    logic [`LSU_XLEN-1:0] data;   // Store data, unsteered
    logic                 we;     // 1 = store
    lsu_size_e            size;
  } lsu_req_t;

  // Store after lane steering
  typedef struct packed {
    logic [`LSU_XLEN-1:0]   addr;
    logic [`LSU_XLEN/8-1:0] be;   // One bit per byte lane
    logic [`LSU_XLEN-1:0]   data; // Already shifted into lanes
  } lsu_wr_t;

  typedef struct packed {
    logic                 hit;    // Address fell in this side's ranges
    logic                 align;  // Load shift and extension apply
    logic [`LSU_XLEN-1:0] data;   // Raw word
  } lsu_rd_t;

  typedef struct packed {
    logic [`LSU_XLEN-1:0] data;
  } lsu_rsp_t;

  typedef struct packed {
    logic [`LSU_LEDR_W-1:0]                         ledr;
    logic [`LSU_LEDG_W-1:0]                         ledg;
    logic [`LSU_HEX_DIGITS-1:0][`LSU_HEX_SEG_W-1:0] hex;  // hex[0] is digit 0
  } lsu_board_t;

endpackage

/* src/lsu_store_merge.sv */
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_store_merge
  import lsu_pkg::*;
(
  input  lsu_req_t i_req,
  output lsu_wr_t  o_wr
);

  logic [1:0]             offset;     // Byte offset k within the word
  logic [`LSU_XLEN/8-1:0] lane_mask;  // Lanes before shifting by k

  assign offset = i_req.addr[1:0];

  // Lanes covered by the access, counted from lane 0
  always_comb begin
    case (i_req.size)
      LSU_W: begin
        lane_mask = 4'b1111;
      end
      LSU_H, LSU_HU: begin
        lane_mask = (offset == 2'd3) ? 4'b0000 : 4'b0011;  // SH at k=3 dropped
      end
      LSU_B, LSU_BU: begin
        lane_mask = 4'b0001;
      end
      default: begin
        lane_mask = 4'b0000;  // Invalid codes 3, 6 and 7
      end
    endcase
  end

  // Upper lanes fall off the word, so a word store at k keeps bytes 0..3-k
  always_comb begin
    o_wr.addr = i_req.addr;
    if (i_req.we) begin
      o_wr.be = lane_mask << offset;
    end else begin
      o_wr.be = '0;
    end
    o_wr.data = i_req.data << {offset, 3'b000};
  end

endmodule

/* src/lsu_data_ram.sv */
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_data_ram
  import lsu_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_req_fire,
  input  lsu_req_t i_req,
  input  lsu_wr_t  i_wr,
  output lsu_rd_t  o_rd
);

  localparam int AW    = $clog2(`LSU_RAM_WORDS);  // Word index width
  localparam int LANES = `LSU_XLEN / 8;

  logic [`LSU_XLEN-1:0] mem [`LSU_RAM_WORDS];

  logic          wr_hit;
  logic          rd_hit;
  logic [AW-1:0] wr_idx;
  logic [AW-1:0] rd_idx;

  assign wr_hit = (i_wr.addr >= `LSU_RAM_BASE) && (i_wr.addr <= `LSU_RAM_LAST);
  assign rd_hit = (i_req.addr >= `LSU_RAM_BASE) && (i_req.addr <= `LSU_RAM_LAST);

  // Base is aligned to the window size, so the low word bits index directly
  assign wr_idx = i_wr.addr[AW+1:2];
  assign rd_idx = i_req.addr[AW+1:2];

  // Byte-enable write
  always_ff @(posedge i_clk) begin
    if (i_req_fire && i_req.we && wr_hit) begin
      for (int i = 0; i < LANES; i++) begin
        if (i_wr.be[i]) begin
          mem[wr_idx][8*i +: 8] <= i_wr.data[8*i +: 8];
        end
      end
    end
  end

  // Registered read, taken on every accepted load so a stale hit cannot linger
  always_ff @(posedge i_clk) begin
    if (i_req_fire && !i_req.we) begin
      o_rd.hit   <= rd_hit;
      o_rd.align <= 1'b1;       // RAM words always go through the load rule
      o_rd.data  <= mem[rd_idx];
    end
  end

endmodule

/* src/lsu_io_regs.sv */
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_io_regs
  import lsu_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_req_fire,
  input  lsu_req_t              i_req,
  input  lsu_wr_t               i_wr,
  input  logic [`LSU_SW_W-1:0]  i_sw,
  input  logic [`LSU_BTN_W-1:0] i_btn,
  output lsu_rd_t               o_rd,
  output lsu_board_t            o_board
);

  localparam int LANES = `LSU_XLEN / 8;

  logic [`LSU_LEDR_W-1:0]            ledr_q;
  logic [`LSU_LEDG_W-1:0]            ledg_q;
  logic [`LSU_HEX_DIGITS-1:0][7:0]   hex_q;   // Full byte kept per digit

  logic                 st_fire;
  logic                 st_ledr;
  logic                 st_ledg;
  logic                 st_hex;
  logic                 ld_hit;
  logic                 ld_align;
  logic [`LSU_XLEN-1:0] ld_data;

  function automatic logic in_range(logic [`LSU_XLEN-1:0] a,
                                    logic [`LSU_XLEN-1:0] lo,
                                    logic [`LSU_XLEN-1:0] hi);
    return (a >= lo) && (a <= hi);
  endfunction

  assign st_fire = i_req_fire && i_req.we;
  assign st_ledr = in_range(i_wr.addr, `LSU_LEDR_BASE, `LSU_LEDR_LAST);
  assign st_ledg = in_range(i_wr.addr, `LSU_LEDG_BASE, `LSU_LEDG_LAST);
  assign st_hex  = in_range(i_wr.addr, `LSU_HEX_BASE, `LSU_HEX_LAST);

  // LED stores ignore size and offset
  always_ff @(posedge i_clk or negedge i_rst) begin
    if (!i_rst) begin
      ledr_q <= '0;
      ledg_q <= '0;
      hex_q  <= '0;
    end else if (st_fire) begin
      if (st_ledr) begin
        ledr_q <= i_req.data[`LSU_LEDR_W-1:0];
      end
      if (st_ledg) begin
        ledg_q <= i_req.data[`LSU_LEDG_W-1:0];
      end
      if (st_hex) begin
        for (int g = 0; g < LANES; g++) begin
          if (i_wr.be[g]) begin
            hex_q[{i_wr.addr[2], g[1:0]}] <= i_wr.data[8*g +: 8];  // addr[2] picks 0-3 or 4-7
          end
        end
      end
    end
  end

  // Load value, switches and buttons sampled here
  always_comb begin
    ld_hit   = 1'b1;
    ld_align = 1'b0;
    ld_data  = '0;
    if (in_range(i_req.addr, `LSU_LEDR_BASE, `LSU_LEDR_LAST)) begin
      ld_data = `LSU_XLEN'(ledr_q);
    end else if (in_range(i_req.addr, `LSU_LEDG_BASE, `LSU_LEDG_LAST)) begin
      ld_data = `LSU_XLEN'(ledg_q);
    end else if (in_range(i_req.addr, `LSU_HEX_BASE, `LSU_HEX_LAST)) begin
      ld_align = 1'b1;
      ld_data  = i_req.addr[2] ? hex_q[7:4] : hex_q[3:0];
    end else if (in_range(i_req.addr, `LSU_SW_BASE, `LSU_SW_LAST)) begin
      ld_data = `LSU_XLEN'(i_sw);
    end else if (in_range(i_req.addr, `LSU_BTN_BASE, `LSU_BTN_LAST)) begin
      ld_data = `LSU_XLEN'(i_btn);
    end else begin
      ld_hit = 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_req_fire && !i_req.we) begin
      o_rd.hit   <= ld_hit;
      o_rd.align <= ld_align;
      o_rd.data  <= ld_data;
    end
  end

  always_comb begin
    o_board.ledr = ledr_q;
    o_board.ledg = ledg_q;
    for (int d = 0; d < `LSU_HEX_DIGITS; d++) begin
      o_board.hex[d] = hex_q[d][`LSU_HEX_SEG_W-1:0];  // Bit 7 not wired out
    end
  end

endmodule

/* src/lsu_load_align.sv */
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_load_align
  import lsu_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_req_valid,
  input  lsu_req_t i_req,
  input  logic     i_rsp_ready,
  input  lsu_rd_t  i_ram_rd,
  input  lsu_rd_t  i_io_rd,
  output logic     o_req_ready,
  output logic     o_req_fire,
  output logic     o_rsp_valid,
  output lsu_rsp_t o_rsp
);

  logic                 rsp_valid_q;
  logic                 rsp_new_q;   // First cycle of a response
  logic                 we_q;
  lsu_size_e            size_q;
  logic [1:0]           off_q;
  lsu_rd_t              sel_rd;
  logic [`LSU_XLEN-1:0] shifted;
  logic [`LSU_XLEN-1:0] aligned;
  logic [`LSU_XLEN-1:0] hold_q;      // Response data kept under stall

  assign o_req_ready = !rsp_valid_q || i_rsp_ready;
  assign o_req_fire  = i_req_valid && o_req_ready;

  always_ff @(posedge i_clk or negedge i_rst) begin
    if (!i_rst) begin
      rsp_valid_q <= 1'b0;
      rsp_new_q   <= 1'b0;
    end else begin
      rsp_new_q <= o_req_fire;
      if (o_req_fire) begin
        rsp_valid_q <= 1'b1;
      end else if (i_rsp_ready) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  // Request attributes for the response one cycle later
  always_ff @(posedge i_clk) begin
    if (o_req_fire) begin
      we_q   <= i_req.we;
      size_q <= i_req.size;
      off_q  <= i_req.addr[1:0];
    end
    if (rsp_new_q) begin
      hold_q <= aligned;
    end
  end

  // At most one side hits, RAM checked first
  assign sel_rd  = i_ram_rd.hit ? i_ram_rd : (i_io_rd.hit ? i_io_rd : '0);
  assign shifted = sel_rd.data >> {off_q, 3'b000};

  always_comb begin
    if (we_q || !sel_rd.hit) begin
      aligned = '0;                  // Stores and unmapped loads
    end else if (!sel_rd.align) begin
      aligned = sel_rd.data;         // Plain register read
    end else begin
      case (size_q)
        LSU_W:   aligned = shifted;
        LSU_H:   aligned = (off_q == 2'd3) ? '0 : {{16{shifted[15]}}, shifted[15:0]};
        LSU_HU:  aligned = (off_q == 2'd3) ? '0 : {16'b0, shifted[15:0]};
        LSU_B:   aligned = {{24{shifted[7]}}, shifted[7:0]};
        LSU_BU:  aligned = {24'b0, shifted[7:0]};
        default: aligned = '0;
      endcase
    end
  end

  assign o_rsp_valid = rsp_valid_q;
  assign o_rsp.data  = rsp_new_q ? aligned : hold_q;

endmodule

/* src/lsu_top.sv */
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_top
  import lsu_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_rst,        // Active low, async
  // Request channel
  input  logic                  i_req_valid,
  input  lsu_req_t              i_req,
  output logic                  o_req_ready,
  // Response channel
  output logic                  o_rsp_valid,
  output lsu_rsp_t              o_rsp,
  input  logic                  i_rsp_ready,
  // Board I/O
  input  logic [`LSU_SW_W-1:0]  i_sw,
  input  logic [`LSU_BTN_W-1:0] i_btn,
  output lsu_board_t            o_board
);

  logic    req_fire;  // Request accepted this cycle
  lsu_wr_t wr;        // Lane-steered store
  lsu_rd_t ram_rd;
  lsu_rd_t io_rd;

  lsu_store_merge lsu_store_merge_i (
    .i_req (i_req),
    .o_wr  (wr)
  );

  lsu_data_ram lsu_data_ram_i (
    .i_clk      (i_clk),
    .i_req_fire (req_fire),
    .i_req      (i_req),
    .i_wr       (wr),
    .o_rd       (ram_rd)
  );

  lsu_io_regs lsu_io_regs_i (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_req_fire (req_fire),
    .i_req      (i_req),
    .i_wr       (wr),
    .i_sw       (i_sw),
    .i_btn      (i_btn),
    .o_rd       (io_rd),
    .o_board    (o_board)
  );

  lsu_load_align lsu_load_align_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_req_valid (i_req_valid),
    .i_req       (i_req),
    .i_rsp_ready (i_rsp_ready),
    .i_ram_rd    (ram_rd),
    .i_io_rd     (io_rd),
    .o_req_ready (o_req_ready),
    .o_req_fire  (req_fire),
    .o_rsp_valid (o_rsp_valid),
    .o_rsp       (o_rsp)
  );

endmodule

/* testbench/lsu_asserts.sv */
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_asserts
  import lsu_pkg::*;
(
  input logic       i_clk,
  input logic       i_rst,
  input logic       i_rsp_ready,
  input logic       o_req_ready,
  input logic       o_rsp_valid,
  input lsu_rsp_t   o_rsp,
  input lsu_board_t o_board
);

  logic stalled;         // Response held and not taken
  int   fail_count = 0;  // Assertion failures so far

  assign stalled = o_rsp_valid && !i_rsp_ready;

  // A held response keeps valid and data until the consumer takes it
  rsp_stable_a: assert property (@(posedge i_clk) disable iff (!i_rst)
      stalled |=> o_rsp_valid && $stable(o_rsp))
    else begin
      fail_count++;
      $error("o_rsp changed or dropped before it was taken");
    end

  ready_low_a: assert property (@(posedge i_clk) disable iff (!i_rst)
      stalled |-> !o_req_ready)
    else begin
      fail_count++;
      $error("o_req_ready high while a response is held");
    end

  board_reset_a: assert property (@(posedge i_clk) !i_rst |-> o_board == '0)
    else begin
      fail_count++;
      $error("o_board not zero during reset");
    end

endmodule

/* testbench/lsu_tb.sv */
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_tb
  import lsu_pkg::*;
();

  localparam int R_NONE = 0;
  localparam int R_RAM  = 1;
  localparam int R_LEDR = 2;
  localparam int R_LEDG = 3;
  localparam int R_HEX  = 4;
  localparam int R_SW   = 5;
  localparam int R_BTN  = 6;

  localparam int M_FILL  = 0;   // Word store to every RAM word
  localparam int M_WORD  = 1;   // Word store, then word load of the same word
  localparam int M_RAM   = 2;
  localparam int M_IO    = 3;
  localparam int M_INPUT = 4;
  localparam int M_ALL   = 5;

  localparam int WAIT_MAX = 100;  // Cycles allowed for one handshake

  logic                  i_clk;
  logic                  i_rst;
  logic                  i_req_valid;
  lsu_req_t              i_req;
  logic                  o_req_ready;
  logic                  o_rsp_valid;
  lsu_rsp_t              o_rsp;
  logic                  i_rsp_ready;
  logic [`LSU_SW_W-1:0]  i_sw;
  logic [`LSU_BTN_W-1:0] i_btn;
  lsu_board_t            o_board;

  int          seed = 72119;
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  bit          timed_out = 0;
  logic [31:0] last_addr;

  logic [7:0]             ram_m [`LSU_RAM_WORDS*4];  // Byte image of the data RAM
  logic [7:0]             hex_m [`LSU_HEX_DIGITS];
  logic [`LSU_LEDR_W-1:0] ledr_m;
  logic [`LSU_LEDG_W-1:0] ledg_m;
  logic [31:0]            exp_q [$];                 // Expected responses, oldest first

  lsu_top lsu_top_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_req_valid (i_req_valid),
    .i_req       (i_req),
    .o_req_ready (o_req_ready),
    .o_rsp_valid (o_rsp_valid),
    .o_rsp       (o_rsp),
    .i_rsp_ready (i_rsp_ready),
    .i_sw        (i_sw),
    .i_btn       (i_btn),
    .o_board     (o_board)
  );

  bind lsu_top lsu_asserts lsu_asserts_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_rsp_ready (i_rsp_ready),
    .o_req_ready (o_req_ready),
    .o_rsp_valid (o_rsp_valid),
    .o_rsp       (o_rsp),
    .o_board     (o_board)
  );

  always #4 i_clk = ~i_clk;

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  function automatic logic [31:0] fill_word(logic [31:0] a);
    return (a * 32'h9E37_79B9) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic int region_of(logic [31:0] a);
    if (a >= `LSU_RAM_BASE && a <= `LSU_RAM_LAST) return R_RAM;
    if (a >= `LSU_LEDR_BASE && a <= `LSU_LEDR_LAST) return R_LEDR;
    if (a >= `LSU_LEDG_BASE && a <= `LSU_LEDG_LAST) return R_LEDG;
    if (a >= `LSU_HEX_BASE && a <= `LSU_HEX_LAST) return R_HEX;
    if (a >= `LSU_SW_BASE && a <= `LSU_SW_LAST) return R_SW;
    if (a >= `LSU_BTN_BASE && a <= `LSU_BTN_LAST) return R_BTN;
    return R_NONE;
  endfunction

  function automatic logic [31:0] pick_addr(int region);
    logic [31:0] r;
    r = rnd();
    case (region)
      R_RAM:   return `LSU_RAM_BASE + (r & 32'h1FFF);
      R_LEDR:  return `LSU_LEDR_BASE + (r & 32'hF);
      R_LEDG:  return `LSU_LEDG_BASE + (r & 32'hF);
      R_HEX:   return `LSU_HEX_BASE + (r & 32'h7);
      R_SW:    return `LSU_SW_BASE + (r & 32'hF);
      R_BTN:   return `LSU_BTN_BASE + (r & 32'hF);
      default: begin
        case (r[31:30])  // below RAM, above RAM, past the digits, far away
          2'd0:    return r & 32'h1FFF;
          2'd1:    return 32'h4000 + (r & 32'h0FFF);
          2'd2:    return `LSU_HEX_LAST + 32'd1 + (r & 32'h7);
          default: return r | 32'h8000_0000;
        endcase
      end
    endcase
  endfunction

  // Bytes a store covers before lanes past 3 are dropped
  function automatic int store_bytes(lsu_size_e s, logic [1:0] k);
    case (s)
      LSU_W:         return 4;
      LSU_H, LSU_HU: return (k == 2'd3) ? 0 : 2;
      LSU_B, LSU_BU: return 1;
      default:       return 0;
    endcase
  endfunction

  function automatic logic [31:0] load_value(lsu_req_t r);
    logic [1:0]  k;
    logic [12:0] boff;
    logic [31:0] w;
    logic [31:0] sh;
    k    = r.addr[1:0];
    boff = 13'(r.addr - `LSU_RAM_BASE);
    case (region_of(r.addr))
      R_LEDR:  return 32'(ledr_m);
      R_LEDG:  return 32'(ledg_m);
      R_SW:    return 32'(i_sw);
      R_BTN:   return 32'(i_btn);
      R_RAM:   w = {ram_m[{boff[12:2], 2'd3}], ram_m[{boff[12:2], 2'd2}],
                    ram_m[{boff[12:2], 2'd1}], ram_m[{boff[12:2], 2'd0}]};
      R_HEX:   w = {hex_m[{r.addr[2], 2'd3}], hex_m[{r.addr[2], 2'd2}],
                    hex_m[{r.addr[2], 2'd1}], hex_m[{r.addr[2], 2'd0}]};
      default: return 32'h0;
    endcase
    sh = w >> (8 * k);  // Zero fill from the top
    case (r.size)
      LSU_W:   return sh;
      LSU_H:   return (k == 2'd3) ? 32'h0 : {{16{sh[15]}}, sh[15:0]};
      LSU_HU:  return (k == 2'd3) ? 32'h0 : {16'h0, sh[15:0]};
      LSU_B:   return {{24{sh[7]}}, sh[7:0]};
      LSU_BU:  return {24'h0, sh[7:0]};
      default: return 32'h0;
    endcase
  endfunction

  function automatic lsu_board_t exp_board();
    lsu_board_t b;
    b.ledr = ledr_m;
    b.ledg = ledg_m;
    for (int d = 0; d < `LSU_HEX_DIGITS; d++) begin
      b.hex[d] = hex_m[d][`LSU_HEX_SEG_W-1:0];
    end
    return b;
  endfunction

  // Model update at the edge that accepts the request
  task automatic accept(input lsu_req_t r);
    logic [1:0]  k;
    logic [1:0]  lane;
    logic [12:0] boff;
    int          n;
    int          reg_id;
    k      = r.addr[1:0];
    reg_id = region_of(r.addr);
    boff   = 13'(r.addr - `LSU_RAM_BASE);
    if (!r.we) begin
      exp_q.push_back(load_value(r));
    end else begin
      exp_q.push_back(32'h0);
      n = store_bytes(r.size, k);
      if (reg_id == R_LEDR) ledr_m = r.data[`LSU_LEDR_W-1:0];
      if (reg_id == R_LEDG) ledg_m = r.data[`LSU_LEDG_W-1:0];
      for (int j = 0; j < n && int'(k) + j < 4; j++) begin
        lane = 2'(int'(k) + j);
        if (reg_id == R_RAM) ram_m[{boff[12:2], lane}] = r.data[8*j +: 8];
        if (reg_id == R_HEX) hex_m[{r.addr[2], lane}] = r.data[8*j +: 8];
      end
    end
  endtask

  task automatic gen_req(input int mode, input int idx, output lsu_req_t r);
    logic [31:0] x;
    x      = rnd();
    r.data = rnd();
    r.we   = x[0];
    r.size = lsu_size_e'(x[3:1]);
    case (mode)
      M_FILL: begin
        r.addr = `LSU_RAM_BASE + 32'(4 * idx);
        r.data = fill_word(r.addr);
        r.we   = 1'b1;
        r.size = LSU_W;
      end
      M_WORD: begin
        if (idx % 2 == 0) last_addr = pick_addr(R_RAM) & ~32'h3;
        r.addr = last_addr;
        r.we   = (idx % 2 == 0);
        r.size = LSU_W;
      end
      M_RAM:   r.addr = pick_addr(R_RAM);
      M_IO:    r.addr = pick_addr(x[5:4] == 2'd0 ? R_LEDR : (x[5:4] == 2'd1 ? R_LEDG : R_HEX));
      M_INPUT: begin
        r.addr = pick_addr(x[5:4] == 2'd0 ? R_SW : (x[5:4] == 2'd1 ? R_BTN : R_NONE));
        r.we   = x[0] & x[6];  // Mostly loads
      end
      default: r.addr = pick_addr(int'(x[7:4]) % 7);
    endcase
  endtask

  task automatic run_reqs(input int mode, input int count, input bit stall);
    lsu_req_t    r;
    lsu_board_t  eb;
    logic [31:0] exp;
    logic [31:0] x;
    logic        exp_rdy;
    int          issued;
    int          stall_left;
    int          req_wait;
    int          rsp_wait;
    bit          pend;
    bit          fired;
    bit          fired_last;
    issued     = 0;
    stall_left = 0;
    req_wait   = 0;
    rsp_wait   = 0;
    pend       = 0;
    fired_last = 0;
    while ((issued < count || pend || exp_q.size() != 0) && !timed_out) begin
      @(negedge i_clk);
      eb = exp_board();
      checks++;
      if (o_board !== eb) begin
        errors++;
        $display("error: time %0t o_board expected %h actual %h", $time, eb, o_board);
      end
      if (fired_last && !o_rsp_valid) begin
        errors++;
        $display("error: time %0t o_rsp_valid expected 1 actual %b", $time, o_rsp_valid);
      end
      // Ready unless an outstanding response is being held back
      exp_rdy = (exp_q.size() == 0) || i_rsp_ready;
      checks++;
      if (o_req_ready !== exp_rdy) begin
        errors++;
        $display("error: time %0t o_req_ready expected %b actual %b",
                 $time, exp_rdy, o_req_ready);
      end
      if (o_rsp_valid && i_rsp_ready) begin
        rsp_wait = 0;
        if (exp_q.size() == 0) begin
          errors++;
          $display("response at time %0t arrived with no request outstanding", $time);
        end else begin
          exp = exp_q.pop_front();
          checks++;
          if (o_rsp.data !== exp) begin
            errors++;
            $display("error: time %0t o_rsp.data expected %h actual %h", $time, exp, o_rsp.data);
          end
        end
      end else if (exp_q.size() != 0) begin
        rsp_wait++;
      end
      fired      = i_req_valid && o_req_ready;
      fired_last = fired;
      if (fired) begin
        accept(i_req);
        pend     = 0;
        req_wait = 0;
      end else if (pend) begin
        req_wait++;
      end
      if (rsp_wait > WAIT_MAX || req_wait > WAIT_MAX) begin
        $display("timeout: handshake stuck for %0d cycles at time %0t", WAIT_MAX, $time);
        timed_out = 1;
      end
      @(posedge i_clk);
      if (stall && stall_left > 0) begin
        i_rsp_ready <= 1'b0;
        stall_left--;
      end else begin
        i_rsp_ready <= 1'b1;
        if (stall && (rnd() & 32'h3) == 0) stall_left = 1 + int'(rnd() & 32'h7);
      end
      if (!pend) begin
        if (issued < count && !(stall && (rnd() & 32'h7) == 0)) begin
          gen_req(mode, issued, r);
          x = rnd();
          i_req       <= r;
          i_req_valid <= 1'b1;
          i_sw        <= x[`LSU_SW_W-1:0];
          i_btn       <= x[`LSU_XLEN-1 -: `LSU_BTN_W];
          pend   = 1;
          issued++;
        end else begin
          i_req_valid <= 1'b0;
        end
      end
    end
  endtask

  task automatic close_test(input string name, input int err0);
    tests_run++;
    if (errors != err0 || timed_out) begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", tests_run, name, errors - err0);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
  endtask

  initial begin
    int err0;
    i_clk       = 1'b0;
    i_rst       = 1'b1;
    i_req_valid = 1'b0;
    i_req       = '0;
    i_rsp_ready = 1'b0;
    i_sw        = '0;
    i_btn       = '0;
    ledr_m      = '0;
    ledg_m      = '0;
    for (int d = 0; d < `LSU_HEX_DIGITS; d++) begin
      hex_m[d] = 8'h00;
    end
    #1 i_rst = 1'b0;
    repeat (10) @(posedge i_clk);
    i_rst <= 1'b1;
    @(negedge i_clk);
    err0   = errors;
    checks = checks + 3;
    if (o_board !== '0) begin
      errors++;
      $display("error: time %0t o_board expected 0 actual %h", $time, o_board);
    end
    if (o_rsp_valid !== 1'b0) begin
      errors++;
      $display("error: time %0t o_rsp_valid expected 0 actual %b", $time, o_rsp_valid);
    end
    if (o_req_ready !== 1'b1) begin
      errors++;
      $display("error: time %0t o_req_ready expected 1 actual %b", $time, o_req_ready);
    end
    close_test("reset values", err0);
    err0 = errors;
    run_reqs(M_FILL, `LSU_RAM_WORDS, 1'b0);
    run_reqs(M_WORD, 800, 1'b0);
    close_test("ram word store and load", err0);
    err0 = errors;
    run_reqs(M_RAM, 2000, 1'b0);
    close_test("ram mixed sizes and offsets", err0);
    err0 = errors;
    run_reqs(M_IO, 800, 1'b0);
    close_test("leds and digits", err0);
    err0 = errors;
    run_reqs(M_INPUT, 600, 1'b0);
    close_test("switches, buttons and unmapped", err0);
    err0 = errors;
    run_reqs(M_ALL, 2000, 1'b1);
    close_test("response back-pressure", err0);
    errors = errors + lsu_top_i.lsu_asserts_i.fail_count;
    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+src
src/lsu_pkg.sv
src/lsu_store_merge.sv
src/lsu_data_ram.sv
src/lsu_io_regs.sv
src/lsu_load_align.sv
src/lsu_top.sv
testbench/lsu_asserts.sv
testbench/lsu_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module lsu_tb -o Vlsu_tb

status=0
./obj_dir/Vlsu_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation FAILED" sim.log; then
  echo "run failed, see sim.log"
  exit 1
fi
echo "run passed"
